//--- build.f
hw/vecLanePkg.sv
hw/vecAlu.sv
hw/vecMultiplier.sv
hw/vecDivider.sv
hw/vecIssueQueue.sv
hw/vecFu.sv
hw/vecLaneTop.sv
tests/vecLaneTbClk.sv
tests/vecLaneTb.sv

//--- tests/vecLaneTb.sv
`timescale 1ns/10ps
`default_nettype none

module vecLaneTb;

    localparam int NUM_OPS = 60;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40;

    logic              CLK;
    logic              rstN;
    logic              opValid;
    vecLanePkg::vop_t  op;
    logic              creditReturn;
    logic              resValid;
    vecLanePkg::vres_t res;

    logic [31:0]       lfsr = 32'd58;
    vecLanePkg::vop_t  issuedOps [NUM_OPS];
    vecLanePkg::vres_t expRes [NUM_OPS];
    int                opsSent = 0;
    int                creditsReturned = 0; // also the count of pops
    int                resCount = 0;
    int                cycles = 0;
    vecLanePkg::vres_t expectedNow;
    logic              popIsDirect;
    logic              popIsMul;

    vecLaneTbClk i_clk (.CLK);

    vecLaneTop i_dut (
        .CLK,
        .rstN,
        .opValid,
        .op,
        .creditReturn,
        .resValid,
        .res
    );

    task automatic stopWithFailure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string msg);
        $display("ERROR %0t ns: %s", $time, msg);
        stopWithFailure();
    endtask

    function automatic logic [31:0] randBits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0); // galois step
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic int sewWidth(vecLanePkg::vsew_t s);
        return (s == vecLanePkg::SEW8) ? 8 : ((s == vecLanePkg::SEW16) ? 16 : 32);
    endfunction

    function automatic vecLanePkg::word_t widthMask(int w);
        return 32'((64'd1 << w) - 64'd1);
    endfunction

    // low w bits sign extended to 64 when requested
    function automatic logic [63:0] extendLow(vecLanePkg::word_t v, int w, logic sgn);
        logic [63:0] low;
        low = 64'(v) & ((64'd1 << w) - 64'd1);
        if (sgn && low[w-1]) low = low - (64'd1 << w);
        return low;
    endfunction

    function automatic vecLanePkg::word_t aluModel(vecLanePkg::vop_t o);
        logic [32:0] sumIn;
        logic [32:0] sumNc;
        logic        borrowIn;
        logic        lt;
        logic        eq;
        int          sh;
        sumIn = 33'(o.vopA) + 33'(o.vopB) + 33'(o.maskBit);
        sumNc = 33'(o.vopA) + 33'(o.vopB);
        borrowIn = 33'(o.vopA) < (33'(o.vopB) + 33'(o.maskBit));
        sh = int'(o.vopB) & (sewWidth(o.vsew) - 1);
        eq = (o.vopA == o.vopB);
        lt = o.isUnsigned ? (o.vopA < o.vopB) : ($signed(o.vopA) < $signed(o.vopB));
        case (o.subOp.alu)
            vecLanePkg::ADD: return o.vopA + o.vopB;
            vecLanePkg::SUB: return o.vopA - o.vopB;
            vecLanePkg::RSB: return o.vopB - o.vopA;
            vecLanePkg::ADC: return sumIn[31:0];
            vecLanePkg::SBC: return o.vopA - o.vopB - 32'(o.maskBit);
            vecLanePkg::MADC: return 32'(sumIn[32]);
            vecLanePkg::MADC_NC: return 32'(sumNc[32]);
            vecLanePkg::MSBC: return 32'(borrowIn);
            vecLanePkg::MSBC_NB: return 32'(o.vopA < o.vopB);
            vecLanePkg::AND: return o.vopA & o.vopB;
            vecLanePkg::OR: return o.vopA | o.vopB;
            vecLanePkg::XOR: return o.vopA ^ o.vopB;
            vecLanePkg::SLL: return o.vopA << sh;
            vecLanePkg::SRL: return o.vopA >> sh;
            vecLanePkg::SRA: return $signed(o.vopA) >>> sh;
            vecLanePkg::SEQ: return 32'(eq);
            vecLanePkg::SNE: return 32'(!eq);
            vecLanePkg::SLT: return 32'(lt);
            vecLanePkg::SLE: return 32'(lt || eq);
            vecLanePkg::SGT: return 32'(!(lt || eq));
            vecLanePkg::MIN: return lt ? o.vopA : o.vopB;
            vecLanePkg::MAX: return lt ? o.vopB : o.vopA;
            vecLanePkg::MERGE: return o.maskBit ? o.vopB : o.vopA;
            default: return o.vopB; // move
        endcase
    endfunction

    function automatic vecLanePkg::word_t mulModel(vecLanePkg::vop_t o);
        int          w;
        logic [63:0] prod;
        logic [63:0] sel;
        w = sewWidth(o.vsew);
        prod = extendLow(o.vopA, w, o.subOp.mul.op.signA)
            * extendLow(o.vopB, w, o.subOp.mul.op.signB);
        sel = o.subOp.mul.op.retHigh ? (prod >> w) : prod;
        if (o.subOp.mul.op.accumulate) sel = sel + 64'(o.vopC);
        return 32'(sel) & widthMask(w);
    endfunction

    function automatic vecLanePkg::word_t divModel(vecLanePkg::vop_t o);
        int          w;
        logic        sgn;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] q;
        logic [63:0] r;
        w = sewWidth(o.vsew);
        sgn = !o.subOp.div.op.isUnsigned;
        a = extendLow(o.vopA, w, sgn);
        b = extendLow(o.vopB, w, sgn);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn) begin
            q = $signed(a) / $signed(b); // min / -1 gives back the dividend at 64 bits
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return 32'(o.subOp.div.op.remainder ? r : q) & widthMask(w);
    endfunction

    function automatic vecLanePkg::vres_t expectedResult(vecLanePkg::vop_t o);
        vecLanePkg::vres_t r;
        r.tag = o.tag;
        if (o.maskOff) begin
            r.data = o.vopC;
        end else begin
            case (o.vfu)
                vecLanePkg::PASS_VS2: r.data = o.vopB;
                vecLanePkg::ALU: r.data = aluModel(o);
                vecLanePkg::MUL: r.data = mulModel(o);
                vecLanePkg::DIV: r.data = divModel(o);
                default: r.data = o.vopA; // pass vs1, slide-move
            endcase
        end
        return r;
    endfunction

    // 0 is single cycle, 1 multiplier and 2 divider
    function automatic int pathOf(vecLanePkg::vop_t o);
        if (o.maskOff) return 0;
        if (o.vfu == vecLanePkg::MUL) return 1;
        if (o.vfu == vecLanePkg::DIV) return 2;
        return 0;
    endfunction

    function automatic int creditsHeld();
        return vecLanePkg::QUEUE_DEPTH - (opsSent - creditsReturned);
    endfunction

    function automatic vecLanePkg::vop_t makeOp(vecLanePkg::vfu_t vfu, logic [4:0] sub,
            vecLanePkg::vsew_t sew, vecLanePkg::word_t a, vecLanePkg::word_t b,
            vecLanePkg::word_t c = '0, logic mBit = 1'b0, logic mOff = 1'b0);
        vecLanePkg::vop_t o;
        o = '0;
        o.vfu = vfu;
        o.subOp = sub;
        o.vsew = sew;
        o.maskBit = mBit;
        o.maskOff = mOff;
        o.vopA = a;
        o.vopB = b;
        o.vopC = c;
        return o;
    endfunction

    function automatic vecLanePkg::vop_t randomOp();
        vecLanePkg::vop_t o;
        o = '0;
        o.vfu = vecLanePkg::vfu_t'(randBits(3) % 6);
        o.subOp = 5'(randBits(5));
        if (o.vfu == vecLanePkg::ALU) o.subOp.alu = vecLanePkg::valuOp_t'(randBits(5) % 24);
        o.isUnsigned = 1'(randBits(1));
        o.vsew = vecLanePkg::vsew_t'(randBits(2) % 3);
        o.maskOff = (randBits(3) == 32'd0); // about one in eight
        o.maskBit = 1'(randBits(1));
        o.vopA = randBits(32);
        o.vopB = randBits(32);
        o.vopC = randBits(32);
        return o;
    endfunction

    task automatic issueOp(input vecLanePkg::vop_t o);
        vecLanePkg::vop_t taggedOp;
        taggedOp = o;
        taggedOp.tag = opsSent[vecLanePkg::TAG_W-1:0];
        while (creditsHeld() == 0) begin
            @(posedge CLK);
            #1;
        end
        issuedOps[opsSent] = taggedOp;
        expRes[opsSent] = expectedResult(taggedOp);
        op = taggedOp;
        opValid = 1'b1;
        opsSent++;
        @(posedge CLK);
        #1;
        opValid = 1'b0;
    endtask

    always @(posedge CLK) begin
        if (creditReturn) creditsReturned++;
        if (resValid) resCount++;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles with %0d of %0d results",
                cycles, resCount, NUM_OPS);
            stopWithFailure();
        end
    end

    always_comb begin
        expectedNow = expRes[resCount];
        popIsDirect = creditReturn && (pathOf(issuedOps[creditsReturned]) == 0);
        popIsMul = creditReturn && (pathOf(issuedOps[creditsReturned]) == 1);
    end

    resultMatches: assert property (@(posedge CLK) disable iff (!rstN)
        resValid |-> (resCount < opsSent) && (res == expectedNow))
        else reportMismatch($sformatf("result %0d tag %0d data %h, expected tag %0d data %h",
            resCount, res.tag, res.data, expectedNow.tag, expectedNow.data));
    directOneCycle: assert property (@(posedge CLK) disable iff (!rstN)
        popIsDirect |=> resValid)
        else reportMismatch("no result one cycle after a single-cycle pop");
    mulFixedLatency: assert property (@(posedge CLK) disable iff (!rstN)
        popIsMul |-> ##(vecLanePkg::MUL_LATENCY + 1) resValid)
        else reportMismatch("multiply result not at its fixed latency");
    resetQuiet: assert property (@(posedge CLK)
        (!rstN || $rose(rstN)) |-> (!resValid && !creditReturn))
        else reportMismatch("resValid or creditReturn high out of reset");
    creditsBounded: assert property (@(posedge CLK)
        (creditsReturned <= opsSent) && (opsSent - creditsReturned <= vecLanePkg::QUEUE_DEPTH))
        else reportMismatch("credit count out of range");

    initial begin
        rstN = 1'b0;
        opValid = 1'b0;
        op = '0;
        repeat (2) @(posedge CLK);
        #1;
        rstN = 1'b1;
        issueOp(makeOp(vecLanePkg::ALU, vecLanePkg::ADD, vecLanePkg::SEW32, '1, 32'd1));
        issueOp(makeOp(vecLanePkg::ALU, vecLanePkg::MADC, vecLanePkg::SEW32, '1, '0, '0, 1'b1));
        issueOp(makeOp(vecLanePkg::ALU, vecLanePkg::MADC_NC, vecLanePkg::SEW32,
            32'h8000_0000, 32'h8000_0000));
        issueOp(makeOp(vecLanePkg::ALU, vecLanePkg::MSBC, vecLanePkg::SEW32, '0, '0, '0, 1'b1));
        issueOp(makeOp(vecLanePkg::ALU, vecLanePkg::SLL, vecLanePkg::SEW8, 32'd1, 32'hff));
        issueOp(makeOp(vecLanePkg::ALU, vecLanePkg::SRA, vecLanePkg::SEW16,
            32'h8000_0000, 32'h0f));
        issueOp(makeOp(vecLanePkg::ALU, vecLanePkg::SRL, vecLanePkg::SEW32, '1, 32'h3f));
        issueOp(makeOp(vecLanePkg::DIV, 5'b00000, vecLanePkg::SEW8, 32'h80, 32'hff)); // overflow
        issueOp(makeOp(vecLanePkg::DIV, 5'b01000, vecLanePkg::SEW8, 32'h80, 32'hff));
        issueOp(makeOp(vecLanePkg::DIV, 5'b00100, vecLanePkg::SEW16, 32'h1234, '0));
        issueOp(makeOp(vecLanePkg::DIV, 5'b01000, vecLanePkg::SEW32, -32'sd7, '0));
        issueOp(makeOp(vecLanePkg::MUL, 5'b01011, vecLanePkg::SEW32,
            32'h8000_0000, 32'h8000_0000));
        issueOp(makeOp(vecLanePkg::MUL, 5'b00100, vecLanePkg::SEW16,
            32'hffff, 32'hffff, 32'h0001_2345));
        issueOp(makeOp(vecLanePkg::MUL, 5'b01010, vecLanePkg::SEW8, 32'h80, 32'hff));
        issueOp(makeOp(vecLanePkg::MUL, 5'b00011, vecLanePkg::SEW32,
            32'd3, 32'd5, 32'h5a5a_5a5a, 1'b0, 1'b1));
        issueOp(makeOp(vecLanePkg::DIV, 5'b00000, vecLanePkg::SEW32,
            32'd9, '0, 32'hc3c3_c3c3, 1'b0, 1'b1));
        issueOp(makeOp(vecLanePkg::PRM, 5'b00000, vecLanePkg::SEW32, 32'hdead_beef, 32'd1));
        while (opsSent < NUM_OPS) issueOp(randomOp());
        while (resCount < NUM_OPS) @(posedge CLK);
        @(posedge CLK);
        #1;
        if (resCount == NUM_OPS && creditsHeld() == vecLanePkg::QUEUE_DEPTH) begin
            $display("No errors");
            $finish;
        end else begin
            $display("lane idle with %0d credits held and %0d results", creditsHeld(), resCount);
            stopWithFailure();
        end
    end

endmodule

`default_nettype wire

//--- tests/vecLaneTbClk.sv
`timescale 1ns/10ps
`default_nettype none

module vecLaneTbClk (
    output logic CLK
);

    initial CLK = 1'b0;

    always #2 CLK = ~CLK; // 4 ns period

endmodule

`default_nettype wire

//--- hw/vecLaneTop.sv
`timescale 1ns/10ps
`default_nettype none

module vecLaneTop (
    input  wire                   CLK,
    input  wire                   rstN,
    input  wire                   opValid,
    input  wire vecLanePkg::vop_t op,
    output logic                  creditReturn,
    output logic                  resValid,
    output vecLanePkg::vres_t     res
);

    logic             headValid;
    logic             pop;
    vecLanePkg::vop_t headOp;

    vecIssueQueue i_issueQueue (
        .CLK,
        .rstN,
        .opValid,
        .op,
        .pop,
        .headValid,
        .headOp,
        .creditReturn
    );

    vecFu i_fu (
        .CLK,
        .rstN,
        .headValid,
        .headOp,
        .pop,
        .resValid,
        .res
    );

endmodule

`default_nettype wire

//--- hw/vecFu.sv
`timescale 1ns/10ps
`default_nettype none

module vecFu (
    input  wire                   CLK,
    input  wire                   rstN,
    input  wire                   headValid,
    input  wire vecLanePkg::vop_t headOp,
    output logic                  pop,
    output logic                  resValid,
    output vecLanePkg::vres_t     res
);

    localparam int LAST = vecLanePkg::MUL_LATENCY - 1;

    logic                              isMul;
    logic                              isDiv;
    logic                              mulInFlight;
    logic                              mulStart;
    logic                              divStart;
    logic                              mulDone;
    logic                              divDone;
    logic                              divBusy;
    vecLanePkg::word_t                 aluRes;
    vecLanePkg::word_t                 mulRes;
    vecLanePkg::word_t                 divRes;
    vecLanePkg::word_t                 directRes;
    logic [LAST:0]                     mulVld;
    logic [vecLanePkg::TAG_W-1:0]      mulTag [vecLanePkg::MUL_LATENCY];
    logic [vecLanePkg::TAG_W-1:0]      divTag;

    vecAlu i_alu (
        .valuOp     (headOp.subOp.alu),
        .isUnsigned (headOp.isUnsigned),
        .vsew       (headOp.vsew),
        .maskBit    (headOp.maskBit),
        .vopA       (headOp.vopA),
        .vopB       (headOp.vopB),
        .result     (aluRes)
    );

    vecMultiplier i_mul (
        .CLK,
        .rstN,
        .mulStart,
        .mulOp   (headOp.subOp.mul.op),
        .vsew    (headOp.vsew),
        .vopA    (headOp.vopA),
        .vopB    (headOp.vopB),
        .vopC    (headOp.vopC),
        .mulDone,
        .mulRes
    );

    vecDivider i_div (
        .CLK,
        .rstN,
        .divStart,
        .divOp   (headOp.subOp.div.op),
        .vsew    (headOp.vsew),
        .vopA    (headOp.vopA),
        .vopB    (headOp.vopB),
        .divBusy,
        .divDone,
        .divRes
    );

    assign isMul = (headOp.vfu == vecLanePkg::MUL) && !headOp.maskOff;
    assign isDiv = (headOp.vfu == vecLanePkg::DIV) && !headOp.maskOff;
    assign mulInFlight = |mulVld;

    // only multiplies may follow a multiply still in the pipe
    assign pop = headValid && !divBusy && (isMul || !mulInFlight);
    assign mulStart = pop && isMul;
    assign divStart = pop && isDiv;

    always_comb begin
        if (headOp.maskOff) begin
            directRes = headOp.vopC;
        end else begin
            case (headOp.vfu)
                vecLanePkg::PASS_VS1: directRes = headOp.vopA;
                vecLanePkg::PASS_VS2: directRes = headOp.vopB;
                vecLanePkg::ALU: directRes = aluRes;
                vecLanePkg::PRM: directRes = headOp.vopA; // slide-move
                default: directRes = '0;
            endcase
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            mulVld <= '0;
            resValid <= 1'b0;
        end else begin
            mulVld <= {mulVld[LAST-1:0], mulStart};
            resValid <= mulDone || divDone || (pop && !isMul && !isDiv);
        end
    end

    always_ff @(posedge CLK) begin
        mulTag[0] <= headOp.tag;
        for (int i = 1; i < vecLanePkg::MUL_LATENCY; i++) begin
            mulTag[i] <= mulTag[i-1];
        end
        if (divStart) divTag <= headOp.tag;
        if (mulDone) begin
            res <= '{tag: mulTag[LAST], data: mulRes};
        end else if (divDone) begin
            res <= '{tag: divTag, data: divRes};
        end else begin
            res <= '{tag: headOp.tag, data: directRes};
        end
    end

    oneUnitDone: assert property (@(posedge CLK) disable iff (!rstN)
        !(mulDone && divDone));
    noPopWhileDiv: assert property (@(posedge CLK) disable iff (!rstN)
        (divBusy || divDone) |-> !pop);

endmodule

`default_nettype wire

//--- hw/vecIssueQueue.sv
`timescale 1ns/10ps
`default_nettype none

module vecIssueQueue (
    input  wire                   CLK,
    input  wire                   rstN,
    input  wire                   opValid,
    input  wire vecLanePkg::vop_t op,
    input  wire                   pop,
    output logic                  headValid,
    output vecLanePkg::vop_t      headOp,
    output logic                  creditReturn
);

    vecLanePkg::vop_t                                mem [vecLanePkg::QUEUE_DEPTH];
    logic [$clog2(vecLanePkg::QUEUE_DEPTH)-1:0]      wrPtr;
    logic [$clog2(vecLanePkg::QUEUE_DEPTH)-1:0]      rdPtr;
    logic [$clog2(vecLanePkg::QUEUE_DEPTH + 1)-1:0]  count;

    assign headValid = (count != '0);
    assign headOp = mem[rdPtr];
    assign creditReturn = pop; // one credit per popped entry

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (opValid) begin
                if (int'(wrPtr) == vecLanePkg::QUEUE_DEPTH - 1) wrPtr <= '0;
                else wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                if (int'(rdPtr) == vecLanePkg::QUEUE_DEPTH - 1) rdPtr <= '0;
                else rdPtr <= rdPtr + 1'b1;
            end
            case ({opValid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (opValid) mem[wrPtr] <= op;
    end

    // sender must hold a credit for every write
    noWriteWhenFull: assert property (@(posedge CLK) disable iff (!rstN)
        opValid |-> int'(count) < vecLanePkg::QUEUE_DEPTH);
    noPopWhenEmpty: assert property (@(posedge CLK) disable iff (!rstN)
        pop |-> headValid);

endmodule

`default_nettype wire

//--- hw/vecDivider.sv
`timescale 1ns/10ps
`default_nettype none

module vecDivider (
    input  wire                      CLK,
    input  wire                      rstN,
    input  wire                      divStart,
    input  wire vecLanePkg::vdivOp_t divOp,
    input  wire vecLanePkg::vsew_t   vsew,
    input  wire vecLanePkg::word_t   vopA,
    input  wire vecLanePkg::word_t   vopB,
    output logic                     divBusy,
    output logic                     divDone,
    output vecLanePkg::word_t        divRes
);

    typedef enum logic [1:0] {IDLE, RUN, DONE} divState_t;

    divState_t         state;
    logic [5:0]        count;
    vecLanePkg::word_t quo;
    vecLanePkg::word_t rem;
    vecLanePkg::word_t divisor;
    vecLanePkg::word_t dividend;
    vecLanePkg::word_t mask;
    logic              negQ;
    logic              negR;
    logic              divZero;
    logic              isRem;
    vecLanePkg::word_t startMask;
    logic [5:0]        startBits;
    logic [4:0]        msbIdx;
    logic              aNeg;
    logic              bNeg;
    vecLanePkg::word_t aMag;
    vecLanePkg::word_t bMag;
    logic [33:0]       trial;
    vecLanePkg::word_t qFix;
    vecLanePkg::word_t rFix;

    always_comb begin
        startMask = vecLanePkg::sewMask(vsew);
        startBits = vecLanePkg::sewBits(vsew);
        msbIdx = 5'(startBits - 6'd1);
        aNeg = ~divOp.isUnsigned & vopA[msbIdx];
        bNeg = ~divOp.isUnsigned & vopB[msbIdx];
        aMag = (aNeg ? -vopA : vopA) & startMask;
        bMag = (bNeg ? -vopB : vopB) & startMask;
    end

    assign trial = {1'b0, rem, quo[31]} - {2'b00, divisor}; // bit 33 set: restore

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (divStart) begin
                        state <= RUN;
                        count <= startBits;
                    end
                end
                RUN: begin
                    count <= count - 6'd1;
                    if (count == 6'd1) state <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && divStart) begin
            quo <= aMag << (6'd32 - startBits); // dividend msb at bit 31
            rem <= '0;
            divisor <= bMag;
            dividend <= vopA & startMask;
            mask <= startMask;
            negQ <= aNeg ^ bNeg;
            negR <= aNeg;
            divZero <= (bMag == '0);
            isRem <= divOp.remainder;
        end else if (state == RUN) begin
            rem <= trial[33] ? {rem[30:0], quo[31]} : trial[31:0];
            quo <= {quo[30:0], ~trial[33]};
        end
    end

    // most negative / -1 already lands on the dividend here
    always_comb begin
        qFix = negQ ? -quo : quo;
        rFix = negR ? -rem : rem;
        if (divZero) begin
            qFix = '1;
            rFix = dividend;
        end
        divRes = (isRem ? rFix : qFix) & mask;
    end

    assign divBusy = (state != IDLE);
    assign divDone = (state == DONE);

    boundedLatency: assert property (@(posedge CLK) disable iff (!rstN)
        divStart |-> ##[9:33] divDone);

endmodule

`default_nettype wire

//--- hw/vecMultiplier.sv
`timescale 1ns/10ps
`default_nettype none

module vecMultiplier (
    input  wire                      CLK,
    input  wire                      rstN,
    input  wire                      mulStart,
    input  wire vecLanePkg::vmulOp_t mulOp,
    input  wire vecLanePkg::vsew_t   vsew,
    input  wire vecLanePkg::word_t   vopA,
    input  wire vecLanePkg::word_t   vopB,
    input  wire vecLanePkg::word_t   vopC,
    output logic                     mulDone,
    output vecLanePkg::word_t        mulRes
);

    vecLanePkg::word_t  inMask;
    logic [4:0]         msbIdx;
    logic               aNeg;
    logic               bNeg;
    logic               validS1;
    logic               validS2;
    logic signed [32:0] aS1;
    logic signed [32:0] bS1;
    logic               retHighS1;
    logic               accS1;
    vecLanePkg::vsew_t  vsewS1;
    vecLanePkg::word_t  vopCS1;
    logic [63:0]        prodS2;
    logic               retHighS2;
    logic               accS2;
    vecLanePkg::vsew_t  vsewS2;
    vecLanePkg::word_t  vopCS2;
    vecLanePkg::word_t  highPart;
    vecLanePkg::word_t  prodSel;
    vecLanePkg::word_t  accSum;

    always_comb begin
        inMask = vecLanePkg::sewMask(vsew);
        msbIdx = 5'(vecLanePkg::sewBits(vsew) - 6'd1);
        aNeg = mulOp.signA & vopA[msbIdx];
        bNeg = mulOp.signB & vopB[msbIdx];
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            validS1 <= 1'b0;
            validS2 <= 1'b0;
            mulDone <= 1'b0;
        end else begin
            validS1 <= mulStart;
            validS2 <= validS1;
            mulDone <= validS2;
        end
    end

    always_ff @(posedge CLK) begin
        aS1 <= aNeg ? {1'b1, vopA | ~inMask} : {1'b0, vopA & inMask}; // extend to 33 bits
        bS1 <= bNeg ? {1'b1, vopB | ~inMask} : {1'b0, vopB & inMask};
        retHighS1 <= mulOp.retHigh;
        accS1 <= mulOp.accumulate;
        vsewS1 <= vsew;
        vopCS1 <= vopC;
        prodS2 <= aS1 * bS1;
        retHighS2 <= retHighS1;
        accS2 <= accS1;
        vsewS2 <= vsewS1;
        vopCS2 <= vopCS1;
        mulRes <= accSum & vecLanePkg::sewMask(vsewS2);
    end

    always_comb begin
        highPart = 32'(prodS2 >> vecLanePkg::sewBits(vsewS2));
        prodSel = retHighS2 ? highPart : prodS2[31:0];
        accSum = prodSel + (accS2 ? vopCS2 : 32'd0);
    end

endmodule

`default_nettype wire

//--- hw/vecAlu.sv
`timescale 1ns/10ps
`default_nettype none

module vecAlu (
    input  wire vecLanePkg::valuOp_t valuOp,
    input  wire                      isUnsigned,
    input  wire vecLanePkg::vsew_t   vsew,
    input  wire                      maskBit,
    input  wire vecLanePkg::word_t   vopA,
    input  wire vecLanePkg::word_t   vopB,
    output vecLanePkg::word_t        result
);

    logic [4:0]  shamt;
    logic [32:0] sumNc;
    logic [32:0] sumCin;  // maskBit is the carry in
    logic [32:0] diffNb;
    logic [32:0] diffBin; // maskBit is the borrow in
    logic        lessThan;
    logic        equal;

    always_comb begin
        case (vsew)
            vecLanePkg::SEW8: shamt = {2'b00, vopB[2:0]};
            vecLanePkg::SEW16: shamt = {1'b0, vopB[3:0]};
            default: shamt = vopB[4:0];
        endcase
    end

    // bit 32 holds carry out, or the unsigned borrow
    assign sumNc = {1'b0, vopA} + {1'b0, vopB};
    assign sumCin = sumNc + {32'd0, maskBit};
    assign diffNb = {1'b0, vopA} - {1'b0, vopB};
    assign diffBin = diffNb - {32'd0, maskBit};

    assign equal = (vopA == vopB);
    assign lessThan = isUnsigned ? (vopA < vopB) : ($signed(vopA) < $signed(vopB));

    always_comb begin
        case (valuOp)
            vecLanePkg::ADD: result = sumNc[31:0];
            vecLanePkg::SUB: result = diffNb[31:0];
            vecLanePkg::RSB: result = vopB - vopA;
            vecLanePkg::ADC: result = sumCin[31:0];
            vecLanePkg::SBC: result = diffBin[31:0];
            vecLanePkg::MADC: result = {31'd0, sumCin[32]};
            vecLanePkg::MADC_NC: result = {31'd0, sumNc[32]};
            vecLanePkg::MSBC: result = {31'd0, diffBin[32]};
            vecLanePkg::MSBC_NB: result = {31'd0, diffNb[32]};
            vecLanePkg::AND: result = vopA & vopB;
            vecLanePkg::OR: result = vopA | vopB;
            vecLanePkg::XOR: result = vopA ^ vopB;
            vecLanePkg::SLL: result = vopA << shamt;
            vecLanePkg::SRL: result = vopA >> shamt;
            vecLanePkg::SRA: result = $signed(vopA) >>> shamt; // sign of the full word
            vecLanePkg::SEQ: result = {31'd0, equal};
            vecLanePkg::SNE: result = {31'd0, ~equal};
            vecLanePkg::SLT: result = {31'd0, lessThan};
            vecLanePkg::SLE: result = {31'd0, lessThan | equal};
            vecLanePkg::SGT: result = {31'd0, ~(lessThan | equal)};
            vecLanePkg::MIN: result = lessThan ? vopA : vopB;
            vecLanePkg::MAX: result = lessThan ? vopB : vopA;
            vecLanePkg::MERGE: result = maskBit ? vopB : vopA;
            vecLanePkg::MOVE: result = vopB;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/vecLanePkg.sv
`default_nettype none

package vecLanePkg;

    localparam int QUEUE_DEPTH = 4; // also the sender's starting credits
    localparam int MUL_LATENCY = 3;
    localparam int TAG_W = 4;

    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        SEW8,
        SEW16,
        SEW32
    } vsew_t;

    typedef enum logic [2:0] {
        PASS_VS1,
        PASS_VS2,
        ALU,
        MUL,
        DIV,
        PRM
    } vfu_t;

    typedef enum logic [4:0] {
        ADD, SUB, RSB, ADC, SBC,
        MADC, MADC_NC, MSBC, MSBC_NB,
        AND, OR, XOR,
        SLL, SRL, SRA,
        SEQ, SNE, SLT, SLE, SGT,
        MIN, MAX, MERGE, MOVE
    } valuOp_t;

    typedef struct packed {
        logic retHigh;
        logic accumulate; // vd += product
        logic signA;
        logic signB;
    } vmulOp_t;

    typedef struct packed {
        logic       remainder;
        logic       isUnsigned;
        logic [1:0] pad;
    } vdivOp_t;

    // sub-op field, decoded by the selected unit
    typedef union packed {
        valuOp_t alu;
        struct packed {
            logic    pad;
            vmulOp_t op;
        } mul;
        struct packed {
            logic    pad;
            vdivOp_t op;
        } div;
    } vsubOp_u;

    typedef struct packed {
        vfu_t             vfu;
        vsubOp_u          subOp;
        logic             isUnsigned; // alu compares, min/max
        vsew_t            vsew;
        logic             maskOff;
        logic             maskBit;
        logic [TAG_W-1:0] tag;
        word_t            vopA;
        word_t            vopB;
        word_t            vopC; // old vd
    } vop_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        word_t            data;
    } vres_t;

    function automatic logic [5:0] sewBits(vsew_t sew);
        case (sew)
            SEW8: return 6'd8;
            SEW16: return 6'd16;
            default: return 6'd32;
        endcase
    endfunction

    function automatic word_t sewMask(vsew_t sew);
        case (sew)
            SEW8: return 32'h0000_00ff;
            SEW16: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

endpackage

`default_nettype wire
